// File: verilog.f
src/seg7_pkg.sv
src/digit_cfg_if.sv
src/apb_digit_regs.sv
src/seg7_scanner.sv
src/static_hex_latch.sv
src/display_top.sv
verification/display_top_asserts.sv
verification/tb_display_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

log=sim.log

verilator --binary --timing --assert \
    -f verilog.f \
    --top-module tb_display_top \
    -Mdir obj_dir -o sim_tb

./obj_dir/sim_tb 2>&1 | tee "$log"

if grep -q "Result: FAILED" "$log"; then
    echo "Simulation reported errors, see $log"
    exit 1
fi

echo "Simulation finished without errors"

// File: verification/tb_display_top.sv
`timescale 1ns/1ps

module tb_display_top;

    localparam logic [31:0] lfsr_seed    = 32'd69732;
    localparam logic [31:0] lfsr_taps    = 32'h8020_0003;
    localparam int          apb_limit    = 16;
    localparam int          settle_limit = 2 * seg7_pkg::n_digits * seg7_pkg::scan_div;

    logic                clk;
    logic                rst;
    logic                psel;
    logic                penable;
    logic                pwrite;
    seg7_pkg::apb_addr_t paddr;
    seg7_pkg::apb_data_t pwdata;
    seg7_pkg::apb_data_t prdata;
    logic                pready;
    logic                pslverr;
    seg7_pkg::hex_pin_t  hex_out [seg7_pkg::n_digits];
    logic [7:0]          ledr;

    logic [31:0]         lfsr_state;
    logic [31:0]         model_digits;
    logic [7:0]          model_dp;
    logic [7:0]          model_blank;
    logic                model_scan_en;
    seg7_pkg::hex_pin_t  exp_hex [seg7_pkg::n_digits];
    logic [7:0]          exp_ledr;

    display_top display_top_i
    (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .hex0    (hex_out[0]),
        .hex1    (hex_out[1]),
        .hex2    (hex_out[2]),
        .hex3    (hex_out[3]),
        .hex4    (hex_out[4]),
        .hex5    (hex_out[5]),
        .hex6    (hex_out[6]),
        .hex7    (hex_out[7]),
        .ledr    (ledr)
    );

    always #50 clk = ~clk;

    // --------------------------------------------------
    // Random source and reference model
    // --------------------------------------------------

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ lfsr_taps;
        return s >> 1;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++)
        begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return v;
    endfunction

    // Standard glyphs, segment a in bit 0, active high
    function automatic logic [6:0] glyph_gfedcba(input logic [3:0] v);
        case (v)
            4'h0: return 7'h3F;
            4'h1: return 7'h06;
            4'h2: return 7'h5B;
            4'h3: return 7'h4F;
            4'h4: return 7'h66;
            4'h5: return 7'h6D;
            4'h6: return 7'h7D;
            4'h7: return 7'h07;
            4'h8: return 7'h7F;
            4'h9: return 7'h6F;
            4'hA: return 7'h77;
            4'hB: return 7'h7C;
            4'hC: return 7'h39;
            4'hD: return 7'h5E;
            4'hE: return 7'h79;
            default: return 7'h71;
        endcase
    endfunction

    function automatic logic [31:0] model_read(input seg7_pkg::apb_addr_t addr);
        case (addr)
            seg7_pkg::addr_digits: return model_digits;
            seg7_pkg::addr_dp:     return {24'h0, model_dp};
            seg7_pkg::addr_blank:  return {24'h0, model_blank};
            seg7_pkg::addr_ctrl:   return {31'h0, model_scan_en};
            default:               return 32'h0;
        endcase
    endfunction

    task automatic model_display();
        for (int i = 0; i < seg7_pkg::n_digits; i++)
        begin
            if (model_blank[i])
            begin
                exp_hex[i]  = 7'h7F;
                exp_ledr[i] = 1'b0;
            end
            else
            begin
                exp_hex[i]  = ~glyph_gfedcba(model_digits[4 * i +: 4]);
                exp_ledr[i] = model_dp[i];
            end
        end
    endtask

    // --------------------------------------------------
    // Checks and error exit
    // --------------------------------------------------

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
            abort_run($sformatf("mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    function automatic logic display_matches();
        logic ok;
        ok = (ledr === exp_ledr);
        for (int i = 0; i < seg7_pkg::n_digits; i++)
            if (hex_out[i] !== exp_hex[i])
                ok = 1'b0;
        return ok;
    endfunction

    task automatic check_display();
        for (int i = 0; i < seg7_pkg::n_digits; i++)
            check_value($sformatf("hex%0d", i), 32'(hex_out[i]), 32'(exp_hex[i]));
        check_value("ledr", 32'(ledr), 32'(exp_ledr));
    endtask

    // Scan reaches every digit well within the limit
    task automatic wait_display_settled();
        int cycles;
        cycles = 0;
        while (!display_matches())
        begin
            if (cycles == settle_limit)
            begin
                check_display();
                abort_run("display outputs did not settle before the timeout");
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic hold_display(input int cycles);
        for (int c = 0; c < cycles; c++)
        begin
            @(negedge clk);
            check_display();
        end
    endtask

    // --------------------------------------------------
    // APB driver
    // --------------------------------------------------

    task automatic access_reg(input logic wr, input seg7_pkg::apb_addr_t addr,
                              input logic [31:0] wdata, output logic [31:0] rdata,
                              output logic err);
        int cycles;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        cycles  = 0;
        do
        begin
            @(posedge clk);
            cycles++;
            if (cycles > apb_limit)
                abort_run("APB transfer did not complete, pready stayed low");
        end
        while (!pready);
        rdata = prdata;
        err   = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic write_reg(input seg7_pkg::apb_addr_t addr, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        access_reg(1'b1, addr, data, rdata, err);
        check_value("pslverr", 32'(err), 32'h0);
        case (addr)
            seg7_pkg::addr_digits: model_digits  = data;
            seg7_pkg::addr_dp:     model_dp      = data[7:0];
            seg7_pkg::addr_blank:  model_blank   = data[7:0];
            seg7_pkg::addr_ctrl:   model_scan_en = data[0];
            default: ;
        endcase
    endtask

    task automatic read_check(input seg7_pkg::apb_addr_t addr);
        logic [31:0] rdata;
        logic        err;
        access_reg(1'b0, addr, 32'h0, rdata, err);
        check_value("pslverr", 32'(err), 32'h0);
        check_value($sformatf("prdata at 0x%h", addr), rdata, model_read(addr));
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------

    initial
    begin
        logic [31:0]         r;
        logic [31:0]         data;
        seg7_pkg::apb_addr_t addr;
        logic [31:0]         rdata;
        logic                err;

        clk           = 1'b0;
        rst           = 1'b1;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = '0;
        pwdata        = '0;
        lfsr_state    = lfsr_seed;
        model_digits  = 32'h0;
        model_dp      = 8'h00;
        model_blank   = 8'hFF;
        model_scan_en = 1'b0;

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Reset state of display, bus outputs and registers
        model_display();
        check_display();
        check_value("prdata", prdata, 32'h0);
        check_value("pslverr", 32'(pslverr), 32'h0);
        for (int k = 0; k < 4; k++)
            read_check(seg7_pkg::apb_addr_t'(4 * k));

        // Random register traffic on the mapped addresses
        for (int n = 0; n < 24; n++)
        begin
            r = rand_bits(2);
            addr = {r[1:0], 2'b00};
            write_reg(addr, rand_bits(32));
            r = rand_bits(2);
            read_check({r[1:0], 2'b00});
        end

        // Unmapped addresses answer with an error and change nothing
        for (int n = 0; n < 8; n++)
        begin
            r = rand_bits(4);
            addr = r[3:0];
            if (addr[1:0] == 2'b00)
                addr[1:0] = 2'b11;
            access_reg(1'b1, addr, rand_bits(32), rdata, err);
            check_value("pslverr", 32'(err), 32'h1);
            access_reg(1'b0, addr, 32'h0, rdata, err);
            check_value("pslverr", 32'(err), 32'h1);
            check_value("prdata", rdata, 32'h0);
        end
        for (int k = 0; k < 4; k++)
            read_check(seg7_pkg::apb_addr_t'(4 * k));

        // Scanned digits, decimal points and blanking
        for (int n = 0; n < 4; n++)
        begin
            write_reg(seg7_pkg::addr_digits, rand_bits(32));
            write_reg(seg7_pkg::addr_dp, rand_bits(8));
            r = rand_bits(8);
            data = rand_bits(8);
            write_reg(seg7_pkg::addr_blank, (n == 0) ? 32'h0 : (r & data));
            write_reg(seg7_pkg::addr_ctrl, 32'h1);
            model_display();
            wait_display_settled();
        end

        // Scan off, so the static outputs keep the last picture
        write_reg(seg7_pkg::addr_ctrl, 32'h0);
        write_reg(seg7_pkg::addr_digits, ~model_digits);
        write_reg(seg7_pkg::addr_dp, {24'h0, ~model_dp});
        write_reg(seg7_pkg::addr_blank, 32'h0);
        hold_display(settle_limit);
        for (int k = 0; k < 4; k++)
            read_check(seg7_pkg::apb_addr_t'(4 * k));

        $display("Result: PASSED");
        $finish;
    end

endmodule

// File: verification/display_top_asserts.sv
`timescale 1ns/1ps

module display_top_asserts
(
    input logic                 clk,
    input logic                 rst,
    input logic                 psel,
    input logic                 penable,
    input seg7_pkg::apb_addr_t  paddr,
    input logic                 pslverr,
    input seg7_pkg::digit_sel_t digit
);

    // Scanner drives at most one digit at a time
    digit_one_hot: assert property (@(posedge clk) $onehot0(digit))
        else $error("digit select has more than one bit set");

    digit_idle_in_reset: assert property (@(posedge clk) rst |-> (digit == '0))
        else $error("digit select is active while reset is high");

    // Error response only in an access phase, and only off the word-aligned map
    slverr_in_access: assert property (@(posedge clk)
        pslverr |-> (psel && penable && (paddr[1:0] != 2'b00)))
        else $error("pslverr is set outside of an access phase or for a mapped address");

endmodule

bind display_top display_top_asserts u_asserts
(
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .paddr   (paddr),
    .pslverr (pslverr),
    .digit   (digit)
);

// File: src/display_top.sv
`timescale 1ns/1ps

module display_top
(
    input  logic                            clk,
    input  logic                            rst,

    input  logic                            psel,
    input  logic                            penable,
    input  logic                            pwrite,
    input  seg7_pkg::apb_addr_t             paddr,
    input  seg7_pkg::apb_data_t             pwdata,
    output seg7_pkg::apb_data_t             prdata,
    output logic                            pready,
    output logic                            pslverr,

    output seg7_pkg::hex_pin_t              hex0,
    output seg7_pkg::hex_pin_t              hex1,
    output seg7_pkg::hex_pin_t              hex2,
    output seg7_pkg::hex_pin_t              hex3,
    output seg7_pkg::hex_pin_t              hex4,
    output seg7_pkg::hex_pin_t              hex5,
    output seg7_pkg::hex_pin_t              hex6,
    output seg7_pkg::hex_pin_t              hex7,
    output logic [seg7_pkg::n_digits - 1:0] ledr
);

    // Dynamic display between scanner and latch
    seg7_pkg::seg_t       abcdefgh;
    seg7_pkg::digit_sel_t digit;

    digit_cfg_if u_cfg ();

    // --------------------------------------------------
    // Host registers
    // --------------------------------------------------

    apb_digit_regs u_regs
    (
        .clk     (clk),
        .rst     (rst),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .cfg     (u_cfg.cfg_src)
    );

    // --------------------------------------------------
    // Scan and static conversion
    // --------------------------------------------------

    seg7_scanner u_scanner
    (
        .clk      (clk),
        .rst      (rst),
        .cfg      (u_cfg.cfg_dst),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

    static_hex_latch u_latch
    (
        .clk      (clk),
        .rst      (rst),
        .abcdefgh (abcdefgh),
        .digit    (digit),
        .hex0     (hex0),
        .hex1     (hex1),
        .hex2     (hex2),
        .hex3     (hex3),
        .hex4     (hex4),
        .hex5     (hex5),
        .hex6     (hex6),
        .hex7     (hex7),
        .ledr     (ledr)
    );

endmodule

// File: src/static_hex_latch.sv
`timescale 1ns/1ps

module static_hex_latch
(
    input  logic                          clk,
    input  logic                          rst,
    input  seg7_pkg::seg_t                abcdefgh,
    input  seg7_pkg::digit_sel_t          digit,
    output seg7_pkg::hex_pin_t            hex0,
    output seg7_pkg::hex_pin_t            hex1,
    output seg7_pkg::hex_pin_t            hex2,
    output seg7_pkg::hex_pin_t            hex3,
    output seg7_pkg::hex_pin_t            hex4,
    output seg7_pkg::hex_pin_t            hex5,
    output seg7_pkg::hex_pin_t            hex6,
    output seg7_pkg::hex_pin_t            hex7,
    output logic [seg7_pkg::n_digits - 1:0] ledr
);

    seg7_pkg::seg_t     hgfedcba;
    seg7_pkg::hex_pin_t hex_r [seg7_pkg::n_digits];

    // Segment a ends up in bit 0 for the HEX pins
    always_comb
    begin
        for (int i = 0; i < $bits(seg7_pkg::seg_t); i++)
            hgfedcba[i] = abcdefgh[$bits(seg7_pkg::seg_t) - 1 - i];
    end

    // --------------------------------------------------
    // Sticky flops, one set per digit
    // --------------------------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            // Active low pins, so all dark
            for (int i = 0; i < seg7_pkg::n_digits; i++)
                hex_r[i] <= '1;
            ledr <= '0;
        end
        else
        begin
            for (int i = 0; i < seg7_pkg::n_digits; i++)
            begin
                if (digit[i])
                begin
                    hex_r[i] <= ~hgfedcba[6:0];
                    ledr[i]  <= hgfedcba[7];
                end
            end
        end
    end

    assign hex0 = hex_r[0];
    assign hex1 = hex_r[1];
    assign hex2 = hex_r[2];
    assign hex3 = hex_r[3];
    assign hex4 = hex_r[4];
    assign hex5 = hex_r[5];
    assign hex6 = hex_r[6];
    assign hex7 = hex_r[7];

endmodule

// File: src/seg7_scanner.sv
`timescale 1ns/1ps

module seg7_scanner
(
    input  logic                 clk,
    input  logic                 rst,
    digit_cfg_if.cfg_dst         cfg,
    output seg7_pkg::seg_t       abcdefgh,
    output seg7_pkg::digit_sel_t digit
);

    seg7_pkg::scan_cnt_t  tick_cnt;
    logic                 tick;
    seg7_pkg::digit_sel_t next_sel;
    seg7_pkg::hex_t       next_val;
    logic                 next_dp;
    logic                 next_blank;
    seg7_pkg::seg_t       next_seg;

    // --------------------------------------------------
    // Scan rate divider
    // --------------------------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            tick_cnt <= '0;
        else if (!cfg.scan_en || tick)
            tick_cnt <= '0;
        else
            tick_cnt <= tick_cnt + 1'b1;
    end

    assign tick = cfg.scan_en
               && (tick_cnt == seg7_pkg::scan_cnt_t'(seg7_pkg::scan_div - 1));

    // --------------------------------------------------
    // Next digit and its pattern
    // --------------------------------------------------

    always_comb
    begin
        // Start at digit 0 when idle, otherwise rotate up
        if (digit == '0)
            next_sel = seg7_pkg::digit_sel_t'(1);
        else
            next_sel = {digit[seg7_pkg::n_digits - 2:0], digit[seg7_pkg::n_digits - 1]};

        next_val   = '0;
        next_dp    = 1'b0;
        next_blank = 1'b0;

        for (int i = 0; i < seg7_pkg::n_digits; i++)
        begin
            if (next_sel[i])
            begin
                next_val   = cfg.digits[i];
                next_dp    = cfg.dp_mask[i];
                next_blank = cfg.blank_mask[i];
            end
        end
    end

    // Decimal point goes into h, bit 0
    assign next_seg = next_blank ? '0
                    : (seg7_pkg::hex_to_seg(next_val) | seg7_pkg::seg_t'(next_dp));

    // Pattern and select move together
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            digit    <= '0;
            abcdefgh <= '0;
        end
        else if (!cfg.scan_en)
        begin
            digit    <= '0;
            abcdefgh <= '0;
        end
        else if (tick)
        begin
            digit    <= next_sel;
            abcdefgh <= next_seg;
        end
    end

endmodule

// File: src/apb_digit_regs.sv
`timescale 1ns/1ps

module apb_digit_regs
(
    input  logic                clk,
    input  logic                rst,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  seg7_pkg::apb_addr_t paddr,
    input  seg7_pkg::apb_data_t pwdata,
    output seg7_pkg::apb_data_t prdata,
    output logic                pready,
    output logic                pslverr,
    digit_cfg_if.cfg_src        cfg
);

    seg7_pkg::digit_vec_t  digits_r;
    seg7_pkg::digit_mask_t dp_r;
    seg7_pkg::digit_mask_t blank_r;
    logic                  scan_en_r;

    logic                  access;
    logic                  addr_ok;
    logic                  wr_en;
    seg7_pkg::apb_data_t   rd_mux;

    // --------------------------------------------------
    // Address decode
    // --------------------------------------------------

    assign access = psel && penable;

    always_comb
    begin
        case (paddr)
            seg7_pkg::addr_digits,
            seg7_pkg::addr_dp,
            seg7_pkg::addr_blank,
            seg7_pkg::addr_ctrl: addr_ok = 1'b1;
            default:             addr_ok = 1'b0;
        endcase
    end

    assign wr_en   = access && pwrite && addr_ok;

    // No wait states
    assign pready  = 1'b1;
    assign pslverr = access && !addr_ok;

    // --------------------------------------------------
    // Registers
    // --------------------------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            digits_r  <= seg7_pkg::digits_rst;
            dp_r      <= seg7_pkg::dp_rst;
            blank_r   <= seg7_pkg::blank_rst;
            scan_en_r <= seg7_pkg::scan_en_rst;
        end
        else if (wr_en)
        begin
            case (paddr)
                seg7_pkg::addr_digits: digits_r  <= pwdata;
                seg7_pkg::addr_dp:     dp_r      <= pwdata[seg7_pkg::n_digits - 1:0];
                seg7_pkg::addr_blank:  blank_r   <= pwdata[seg7_pkg::n_digits - 1:0];
                default:               scan_en_r <= pwdata[0];
            endcase
        end
    end

    // --------------------------------------------------
    // Read back
    // --------------------------------------------------

    always_comb
    begin
        case (paddr)
            seg7_pkg::addr_digits: rd_mux = digits_r;
            seg7_pkg::addr_dp:     rd_mux = seg7_pkg::apb_data_t'(dp_r);
            seg7_pkg::addr_blank:  rd_mux = seg7_pkg::apb_data_t'(blank_r);
            seg7_pkg::addr_ctrl:   rd_mux = seg7_pkg::apb_data_t'(scan_en_r);
            default:               rd_mux = '0;
        endcase
    end

    // Only valid in a read access phase
    assign prdata = (access && !pwrite) ? rd_mux : '0;

    assign cfg.digits     = digits_r;
    assign cfg.dp_mask    = dp_r;
    assign cfg.blank_mask = blank_r;
    assign cfg.scan_en    = scan_en_r;

endmodule

// File: src/digit_cfg_if.sv
`timescale 1ns/1ps

interface digit_cfg_if;

    // Hex value per digit, digit 0 in the low nibble
    seg7_pkg::digit_vec_t  digits;

    // Per-digit decimal point and blanking
    seg7_pkg::digit_mask_t dp_mask;
    seg7_pkg::digit_mask_t blank_mask;

    // Scanner runs only while set
    logic                  scan_en;

    // Register block side
    modport cfg_src (output digits, dp_mask, blank_mask, scan_en);

    // Scanner side
    modport cfg_dst (input digits, dp_mask, blank_mask, scan_en);

endinterface

// File: src/seg7_pkg.sv
package seg7_pkg;

    // --------------------------------------------------
    // Board geometry and bus widths
    // --------------------------------------------------

    localparam int n_digits   = 8;
    localparam int scan_div   = 16;
    localparam int scan_cnt_w = $clog2(scan_div);

    typedef logic [3:0]            hex_t;
    typedef logic [7:0]            seg_t;
    typedef logic [6:0]            hex_pin_t;
    typedef logic [n_digits - 1:0] digit_sel_t;
    typedef logic [n_digits - 1:0] digit_mask_t;
    typedef hex_t [n_digits - 1:0] digit_vec_t;
    typedef logic [scan_cnt_w - 1:0] scan_cnt_t;
    typedef logic [3:0]            apb_addr_t;
    typedef logic [31:0]           apb_data_t;

    // --------------------------------------------------
    // Register map and reset values
    // --------------------------------------------------

    localparam apb_addr_t   addr_digits = 4'h0;
    localparam apb_addr_t   addr_dp     = 4'h4;
    localparam apb_addr_t   addr_blank  = 4'h8;
    localparam apb_addr_t   addr_ctrl   = 4'hC;

    localparam digit_vec_t  digits_rst  = '0;
    localparam digit_mask_t dp_rst      = '0;
    localparam digit_mask_t blank_rst   = '1;
    localparam logic        scan_en_rst = 1'b0;

    // Glyphs in abcdefgh order, decimal point left clear
    function automatic seg_t hex_to_seg(input hex_t value);
        case (value)
            4'h0: return 8'b1111_1100;
            4'h1: return 8'b0110_0000;
            4'h2: return 8'b1101_1010;
            4'h3: return 8'b1111_0010;
            4'h4: return 8'b0110_0110;
            4'h5: return 8'b1011_0110;
            4'h6: return 8'b1011_1110;
            4'h7: return 8'b1110_0000;
            4'h8: return 8'b1111_1110;
            4'h9: return 8'b1111_0110;
            4'hA: return 8'b1110_1110;
            4'hB: return 8'b0011_1110;
            4'hC: return 8'b1001_1100;
            4'hD: return 8'b0111_1010;
            4'hE: return 8'b1001_1110;
            default: return 8'b1000_1110;
        endcase
    endfunction

endpackage
